// File: bench/tb_usb_tx.sv
// Testbench for the USB transmit path
// Plays the credit-based producer, decodes the NRZI line with bit
// unstuffing and compares every packet with a reference model

`timescale 1ns/1ps

module tb_usb_tx import usb_tx_pkg::*; ();

	localparam int FIFO_DEPTH   = 16;
	localparam int CLKS_PER_BIT = 4;
	localparam int MID          = CLKS_PER_BIT / 2;
	localparam int NUM_RANDOM   = 16;
	localparam int NUM_BURST    = 8;
	localparam int NUM_PKTS     = 1 + NUM_RANDOM + NUM_BURST;
	localparam int WAIT_LIMIT   = 5000;
	localparam int MAX_LINE_BITS = (FIFO_DEPTH + 3) * 10;

	logic       clk = 1'b0;
	logic       n_rst;
	logic       wr_valid;
	logic [7:0] wr_data;
	logic       wr_last;
	logic       credit_return;
	logic       dp;
	logic       dm;
	logic       tx_active;

	logic [15:0] lfsr;
	logic [7:0]  pkt_buf [$];
	logic [7:0]  exp_data [$];
	int          exp_len [$];
	logic [7:0]  rx_q [$];
	int          credits;
	int          min_credits;

	usb_tx #(
		.FIFO_DEPTH  (FIFO_DEPTH),
		.CLKS_PER_BIT(CLKS_PER_BIT)
	) dut (
		.clk          (clk),
		.n_rst        (n_rst),
		.wr_valid     (wr_valid),
		.wr_data      (wr_data),
		.wr_last      (wr_last),
		.credit_return(credit_return),
		.dp           (dp),
		.dm           (dm),
		.tx_active    (tx_active)
	);

	always #5 clk = ~clk;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TEST RESULT: FAIL");
		$fatal(1, "Simulation stopped on error");
	endtask

	task automatic check_equal(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp)
			abort_run($sformatf("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp));
	endtask

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic rand_bit();
		logic fb;
		fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
		lfsr = {lfsr[14:0], fb};
		return fb;
	endfunction

	function automatic int rand_num(input int nbits);
		int v;
		v = 0;
		for (int i = 0; i < nbits; i++)
			v = (v << 1) | int'(rand_bit());
		return v;
	endfunction

	// Reference CRC16 stepped one data bit at a time LSB first
	function automatic logic [15:0] crc16_ref(input logic [15:0] crc_in, input logic [7:0] b);
		logic [15:0] c;
		logic        fb;
		c = crc_in;
		for (int k = 0; k < 8; k++) begin
			fb = c[0] ^ b[k];
			c = {1'b0, c[15:1]} ^ (fb ? CRC16_POLY_REFL : 16'h0000);
		end
		return c;
	endfunction

	task automatic wait_cycles(input int n);
		repeat (n) @(negedge clk);
	endtask

	task automatic check_idle_line(input int n);
		repeat (n) begin
			wait_cycles(1);
			check_equal("dp", 32'(dp), 32'(1));
			check_equal("dm", 32'(dm), 32'(0));
			check_equal("tx_active", 32'(tx_active), 32'(0));
			check_equal("credit_return", 32'(credit_return), 32'(0));
		end
	endtask

	// Producer clock step that also collects returned credits
	task automatic next_cycle();
		@(negedge clk);
		wr_valid = 1'b0;
		wr_last  = 1'b0;
		if (credit_return)
			credits++;
		if (credits > FIFO_DEPTH)
			abort_run("Credit returned for a byte that was never written");
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) next_cycle();
	endtask

	task automatic write_byte(input logic [7:0] d, input logic last);
		int waited;
		waited = 0;
		next_cycle();
		while (credits == 0) begin
			waited++;
			if (waited > WAIT_LIMIT)
				abort_run("Timed out waiting for a credit to come back");
			next_cycle();
		end
		wr_valid = 1'b1;
		wr_data  = d;
		wr_last  = last;
		credits--;
		if (credits < min_credits)
			min_credits = credits;
		exp_data.push_back(d);
	endtask

	task automatic write_packet(input bit with_gaps);
		int n;
		n = pkt_buf.size();
		for (int i = 0; i < n; i++) begin
			write_byte(pkt_buf[i], i == n - 1);
			if (with_gaps && rand_num(2) == 0)
				idle_cycles(1 + rand_num(3));
		end
		exp_len.push_back(n);
	endtask

	task automatic run_producer();
		int len;
		int waited;
		// Long run of ones so that stuffing spans the SYNC boundary
		pkt_buf.delete();
		repeat (12) pkt_buf.push_back(8'hFF);
		write_packet(1'b0);
		// Lengths capped at the FIFO size since a longer packet could never complete
		repeat (NUM_RANDOM) begin
			idle_cycles(rand_num(5));
			len = 1 + rand_num(4);
			pkt_buf.delete();
			repeat (len) pkt_buf.push_back(8'(rand_num(8)));
			write_packet(1'b1);
		end
		// Back-to-back burst that runs the credits down to zero
		repeat (NUM_BURST) begin
			len = 1 + rand_num(4);
			pkt_buf.delete();
			repeat (len) pkt_buf.push_back(8'(rand_num(8)));
			write_packet(1'b0);
		end
		waited = 0;
		next_cycle();
		while (credits != FIFO_DEPTH) begin
			waited++;
			if (waited > WAIT_LIMIT)
				abort_run("Timed out waiting for all credits to return");
			next_cycle();
		end
	endtask

	task automatic await_tx_active();
		int waited;
		waited = 0;
		while (!tx_active) begin
			waited++;
			if (waited > WAIT_LIMIT)
				abort_run("Timed out waiting for tx_active to rise");
			wait_cycles(1);
		end
	endtask

	// Entered in the first clock of the SYNC bit 0
	task automatic decode_packet();
		logic       prev_lvl;
		logic       bit_val;
		logic [7:0] cur;
		int         nbits;
		int         run;
		int         se0_cnt;
		int         guard;
		rx_q.delete();
		prev_lvl = 1'b1;
		cur      = 8'h00;
		nbits    = 0;
		run      = 0;
		guard    = 0;
		wait_cycles(MID);
		while (!(dp == 1'b0 && dm == 1'b0)) begin
			if (dp == dm)
				abort_run("Line shows SE1 inside a packet");
			bit_val  = (dp == prev_lvl);
			prev_lvl = dp;
			if (run == STUFF_RUN) begin
				if (bit_val)
					abort_run("More ones in a row than the stuffing limit allows");
				run = 0;
			end else begin
				run = bit_val ? run + 1 : 0;
				cur = {bit_val, cur[7:1]};
				nbits++;
				if (nbits % 8 == 0)
					rx_q.push_back(cur);
			end
			guard++;
			if (guard > MAX_LINE_BITS)
				abort_run("Packet did not end with SE0");
			wait_cycles(CLKS_PER_BIT);
		end
		check_equal("line_bits_mod8", nbits % 8, 0);
		se0_cnt = 0;
		while (dp == 1'b0 && dm == 1'b0) begin
			se0_cnt++;
			if (se0_cnt > EOP_SE0_BITS)
				abort_run("SE0 held longer than the end of packet");
			wait_cycles(CLKS_PER_BIT);
		end
		check_equal("eop_se0_bits", se0_cnt, EOP_SE0_BITS);
		check_equal("eop_j_dp", 32'(dp), 32'(1));
		check_equal("eop_j_dm", 32'(dm), 32'(0));
		// tx_active stays through the J bit and drops one clock later
		wait_cycles(CLKS_PER_BIT - 1 - MID);
		check_equal("tx_active", 32'(tx_active), 32'(1));
		wait_cycles(1);
		check_equal("tx_active", 32'(tx_active), 32'(0));
		check_equal("idle_dp", 32'(dp), 32'(1));
		check_equal("idle_dm", 32'(dm), 32'(0));
	endtask

	task automatic check_packet();
		int          len;
		logic [15:0] crc;
		logic [7:0]  b;
		if (exp_len.size() == 0)
			abort_run("Packet appeared on the line that was never written");
		len = exp_len.pop_front();
		check_equal("rx_byte_count", rx_q.size(), len + 3);
		check_equal("sync", 32'(rx_q[0]), 32'(SYNC_BYTE));
		crc = CRC16_INIT;
		for (int i = 0; i < len; i++) begin
			b = exp_data.pop_front();
			check_equal($sformatf("payload[%0d]", i), 32'(rx_q[i + 1]), 32'(b));
			crc = crc16_ref(crc, b);
		end
		crc = ~crc;
		check_equal("crc_lo", 32'(rx_q[len + 1]), 32'(crc[7:0]));
		check_equal("crc_hi", 32'(rx_q[len + 2]), 32'(crc[15:8]));
	endtask

	task automatic run_decoder();
		for (int k = 0; k < NUM_PKTS; k++) begin
			await_tx_active();
			decode_packet();
			check_packet();
		end
	endtask

	initial begin
		lfsr         = 16'd23476;
		n_rst        = 1'b0;
		wr_valid     = 1'b0;
		wr_data      = 8'h00;
		wr_last      = 1'b0;
		credits      = FIFO_DEPTH;
		min_credits  = FIFO_DEPTH;
		wait_cycles(3);
		n_rst = 1'b1;
		check_idle_line(4);

		fork
			run_producer();
			run_decoder();
		join

		check_equal("min_credits", min_credits, 0);
		// No further packet or credit once everything written is out
		check_idle_line(4 * CLKS_PER_BIT);
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build the USB transmit testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module tb_usb_tx \
	-f usb_tx.f \
	-o sim_usb_tx

./obj_dir/sim_usb_tx

// File: src/tx_controller.sv
// Transmit packet sequencer
// Sends SYNC, the buffered payload bytes and the inverted CRC16,
// then requests the end-of-packet from the line encoder

`timescale 1ns/1ps

module tx_controller import usb_tx_pkg::*; (
	input  logic        clk,
	input  logic        n_rst,
	input  logic        pkt_ready,
	input  logic [7:0]  rd_data,
	input  logic        rd_last,
	input  logic [15:0] crc,
	input  logic        byte_sent,
	input  logic        eop_done,
	output logic        rd_en,
	output logic        crc_clear,
	output logic        crc_update,
	output logic        load,
	output logic [7:0]  tx_byte,
	output logic        eop_start,
	output logic        tx_active
);

	localparam logic [2:0] ST_IDLE   = 3'd0;
	localparam logic [2:0] ST_SYNC   = 3'd1;
	localparam logic [2:0] ST_DATA   = 3'd2;
	localparam logic [2:0] ST_CRC_LO = 3'd3;
	localparam logic [2:0] ST_CRC_HI = 3'd4;
	localparam logic [2:0] ST_EOP    = 3'd5;

	logic [2:0] state;
	logic [2:0] next_state;
	// Byte now on the line closes the payload
	logic       last_sent;

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			state     <= ST_IDLE;
			last_sent <= 1'b0;
		end else begin
			state <= next_state;
			if (rd_en)
				last_sent <= rd_last;
		end
	end

	always_comb begin
		next_state = state;
		rd_en      = 1'b0;
		crc_clear  = 1'b0;
		crc_update = 1'b0;
		load       = 1'b0;
		tx_byte    = rd_data;
		eop_start  = 1'b0;

		case (state)
			ST_IDLE: begin
				crc_clear = 1'b1;
				tx_byte   = SYNC_BYTE;
				if (pkt_ready) begin
					load       = 1'b1;
					next_state = ST_SYNC;
				end
			end
			ST_SYNC: begin
				// First payload byte follows SYNC directly
				if (byte_sent) begin
					load       = 1'b1;
					rd_en      = 1'b1;
					crc_update = 1'b1;
					next_state = ST_DATA;
				end
			end
			ST_DATA: begin
				if (byte_sent) begin
					load = 1'b1;
					if (last_sent) begin
						tx_byte    = ~crc[7:0];
						next_state = ST_CRC_LO;
					end else begin
						rd_en      = 1'b1;
						crc_update = 1'b1;
					end
				end
			end
			ST_CRC_LO: begin
				tx_byte = ~crc[15:8];
				if (byte_sent) begin
					load       = 1'b1;
					next_state = ST_CRC_HI;
				end
			end
			ST_CRC_HI: begin
				if (byte_sent) begin
					eop_start  = 1'b1;
					next_state = ST_EOP;
				end
			end
			ST_EOP: begin
				if (eop_done)
					next_state = ST_IDLE;
			end
			default: begin
				next_state = ST_IDLE;
			end
		endcase
	end

	assign tx_active = (state != ST_IDLE);

	// Encoder only finishes a byte while one of ours is on the line
	assert property (@(posedge clk) disable iff (!n_rst)
		byte_sent |-> (state != ST_IDLE && state != ST_EOP));

	// End of packet only completes after it was requested
	assert property (@(posedge clk) disable iff (!n_rst)
		eop_done |-> (state == ST_EOP));

endmodule

// File: src/tx_crc16.sv
// Payload CRC16 generator
// Running USB CRC16 register, updated one byte per cycle LSB first

`timescale 1ns/1ps

module tx_crc16 import usb_tx_pkg::*; (
	input  logic        clk,
	input  logic        n_rst,
	input  logic        crc_clear,
	input  logic        crc_update,
	input  logic [7:0]  data,
	output logic [15:0] crc
);

	logic [15:0] crc_reg;

	// Eight serial steps of the reflected LFSR
	function automatic logic [15:0] crc_byte(input logic [15:0] cur, input logic [7:0] d);
		logic [15:0] r;
		r = cur;
		for (int i = 0; i < 8; i++) begin
			if (r[0] ^ d[i])
				r = (r >> 1) ^ CRC16_POLY_REFL;
			else
				r = r >> 1;
		end
		return r;
	endfunction

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			crc_reg <= CRC16_INIT;
		end else if (crc_clear) begin
			crc_reg <= CRC16_INIT;
		end else if (crc_update) begin
			crc_reg <= crc_byte(crc_reg, data);
		end
	end

	assign crc = crc_reg;

endmodule

// File: src/tx_line_encoder.sv
// Full-speed USB line encoder
// Serializes bytes LSB first with bit stuffing and NRZI coding,
// and generates the SE0/J end-of-packet on request

`timescale 1ns/1ps

module tx_line_encoder import usb_tx_pkg::*; #(
	parameter int CLKS_PER_BIT = 4
) (
	input  logic       clk,
	input  logic       n_rst,
	input  logic       load,
	input  logic [7:0] tx_byte,
	input  logic       eop_start,
	output logic       byte_sent,
	output logic       eop_done,
	output logic       dp,
	output logic       dm
);

	localparam int CNT_W = $clog2(CLKS_PER_BIT);
	localparam int RUN_W = $clog2(STUFF_RUN + 1);
	localparam int EOP_W = (EOP_SE0_BITS > 1) ? $clog2(EOP_SE0_BITS) : 1;

	localparam logic [1:0] M_IDLE = 2'd0;
	localparam logic [1:0] M_DATA = 2'd1;
	localparam logic [1:0] M_SE0  = 2'd2;
	localparam logic [1:0] M_J    = 2'd3;

	logic [1:0]       mode;
	logic [CNT_W-1:0] clk_cnt;
	logic [7:0]       shreg;
	logic [2:0]       bits_left;
	logic [RUN_W-1:0] ones_cnt;
	logic [EOP_W-1:0] eop_cnt;
	// Line level, high is J
	logic             nrzi;
	logic             bit_end;
	logic             need_stuff;
	logic             next_data;

	assign bit_end    = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));
	assign need_stuff = (ones_cnt == RUN_W'(STUFF_RUN));
	// Start another data bit of the current byte
	assign next_data  = (mode == M_DATA) && bit_end && !need_stuff && (bits_left != 3'd0);

	// Stuffed bit after the final data bit still belongs to the byte
	assign byte_sent = (mode == M_DATA) && bit_end && !need_stuff && (bits_left == 3'd0);
	assign eop_done  = (mode == M_J) && bit_end;

	assign dp = (mode == M_SE0) ? 1'b0 : nrzi;
	assign dm = (mode == M_SE0) ? 1'b0 : ~nrzi;

	always_ff @(posedge clk) begin
		if (load)
			shreg <= {1'b0, tx_byte[7:1]};
		else if (next_data)
			shreg <= {1'b0, shreg[7:1]};
	end

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			mode      <= M_IDLE;
			clk_cnt   <= '0;
			bits_left <= 3'd0;
			ones_cnt  <= '0;
			eop_cnt   <= '0;
			nrzi      <= 1'b1;
		end else if (load) begin
			// Bit 0 goes out right away
			mode      <= M_DATA;
			clk_cnt   <= '0;
			bits_left <= 3'd7;
			nrzi      <= tx_byte[0] ? nrzi : ~nrzi;
			ones_cnt  <= tx_byte[0] ? ones_cnt + 1'b1 : '0;
		end else if (eop_start) begin
			mode     <= M_SE0;
			clk_cnt  <= '0;
			eop_cnt  <= '0;
			ones_cnt <= '0;
		end else if (mode != M_IDLE) begin
			if (!bit_end) begin
				clk_cnt <= clk_cnt + 1'b1;
			end else begin
				clk_cnt <= '0;
				case (mode)
					M_DATA: begin
						if (need_stuff) begin
							nrzi     <= ~nrzi;
							ones_cnt <= '0;
						end else if (next_data) begin
							nrzi      <= shreg[0] ? nrzi : ~nrzi;
							ones_cnt  <= shreg[0] ? ones_cnt + 1'b1 : '0;
							bits_left <= bits_left - 1'b1;
						end else begin
							// No follow-up byte, fall back to idle J
							mode     <= M_IDLE;
							nrzi     <= 1'b1;
							ones_cnt <= '0;
						end
					end
					M_SE0: begin
						if (eop_cnt == EOP_W'(EOP_SE0_BITS - 1)) begin
							mode <= M_J;
							nrzi <= 1'b1;
						end else begin
							eop_cnt <= eop_cnt + 1'b1;
						end
					end
					default: begin
						mode <= M_IDLE;
					end
				endcase
			end
		end
	end

	// Controller never asks for a byte and an EOP at once
	assert property (@(posedge clk) disable iff (!n_rst) !(load && eop_start));

endmodule

// File: src/tx_packet_fifo.sv
// Transmit packet FIFO
// Stores payload bytes with an end-of-packet flag, counts complete
// packets and returns one credit per popped entry

`timescale 1ns/1ps

module tx_packet_fifo #(
	parameter int FIFO_DEPTH = 16
) (
	input  logic       clk,
	input  logic       n_rst,
	input  logic       wr_valid,
	input  logic [7:0] wr_data,
	input  logic       wr_last,
	input  logic       rd_en,
	output logic [7:0] rd_data,
	output logic       rd_last,
	output logic       pkt_ready,
	output logic       credit_return
);

	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	// Each entry is {last, data}
	logic [8:0]       mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic [CNT_W-1:0] pkt_cnt;
	logic             full;
	logic             empty;
	logic             wr_pkt_end;
	logic             rd_pkt_end;

	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign full       = (count == CNT_W'(FIFO_DEPTH));
	assign empty      = (count == '0);
	assign wr_pkt_end = wr_valid && wr_last;
	assign rd_pkt_end = rd_en && rd_last;

	// Show-ahead read of the oldest entry
	assign rd_data   = mem[rd_ptr][7:0];
	assign rd_last   = mem[rd_ptr][8];
	assign pkt_ready = (pkt_cnt != '0);

	always_ff @(posedge clk) begin
		if (wr_valid) begin
			mem[wr_ptr] <= {wr_last, wr_data};
		end
	end

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			wr_ptr        <= '0;
			rd_ptr        <= '0;
			count         <= '0;
			pkt_cnt       <= '0;
			credit_return <= 1'b0;
		end else begin
			if (wr_valid)
				wr_ptr <= ptr_inc(wr_ptr);
			if (rd_en)
				rd_ptr <= ptr_inc(rd_ptr);
			count <= count + CNT_W'(wr_valid) - CNT_W'(rd_en);
			// A packet that ends and another that leaves in the same cycle cancel out
			pkt_cnt <= pkt_cnt + CNT_W'(wr_pkt_end) - CNT_W'(rd_pkt_end);
			credit_return <= rd_en;
		end
	end

	// Producer must hold a credit for every write
	assert property (@(posedge clk) disable iff (!n_rst) wr_valid |-> !full);

	// Controller only pops entries of a complete packet
	assert property (@(posedge clk) disable iff (!n_rst) rd_en |-> !empty);

endmodule

// File: src/usb_tx.sv
// Full-speed USB transmit path
// Credit-based write port into a packet FIFO, followed by the
// packet sequencer, CRC16 unit and differential line encoder

`timescale 1ns/1ps

module usb_tx #(
	parameter int FIFO_DEPTH   = 16,
	parameter int CLKS_PER_BIT = 4
) (
	input  logic       clk,
	input  logic       n_rst,
	input  logic       wr_valid,
	input  logic [7:0] wr_data,
	input  logic       wr_last,
	output logic       credit_return,
	output logic       dp,
	output logic       dm,
	output logic       tx_active
);

	logic [7:0]  rd_data;
	logic        rd_last;
	logic        pkt_ready;
	logic        rd_en;
	logic        crc_clear;
	logic        crc_update;
	logic [15:0] crc;
	logic        load;
	logic [7:0]  tx_byte;
	logic        eop_start;
	logic        byte_sent;
	logic        eop_done;

	tx_packet_fifo #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_fifo (
		.clk          (clk),
		.n_rst        (n_rst),
		.wr_valid     (wr_valid),
		.wr_data      (wr_data),
		.wr_last      (wr_last),
		.rd_en        (rd_en),
		.rd_data      (rd_data),
		.rd_last      (rd_last),
		.pkt_ready    (pkt_ready),
		.credit_return(credit_return)
	);

	tx_controller u_ctrl (
		.clk       (clk),
		.n_rst     (n_rst),
		.pkt_ready (pkt_ready),
		.rd_data   (rd_data),
		.rd_last   (rd_last),
		.crc       (crc),
		.byte_sent (byte_sent),
		.eop_done  (eop_done),
		.rd_en     (rd_en),
		.crc_clear (crc_clear),
		.crc_update(crc_update),
		.load      (load),
		.tx_byte   (tx_byte),
		.eop_start (eop_start),
		.tx_active (tx_active)
	);

	// CRC covers the payload bytes as they leave the FIFO
	tx_crc16 u_crc (
		.clk       (clk),
		.n_rst     (n_rst),
		.crc_clear (crc_clear),
		.crc_update(crc_update),
		.data      (rd_data),
		.crc       (crc)
	);

	tx_line_encoder #(
		.CLKS_PER_BIT(CLKS_PER_BIT)
	) u_enc (
		.clk      (clk),
		.n_rst    (n_rst),
		.load     (load),
		.tx_byte  (tx_byte),
		.eop_start(eop_start),
		.byte_sent(byte_sent),
		.eop_done (eop_done),
		.dp       (dp),
		.dm       (dm)
	);

endmodule

// File: src/usb_tx_pkg.sv
// USB transmit shared constants
// Line framing values and CRC16 parameters used by the
// controller, the CRC unit and the line encoder

package usb_tx_pkg;

	// SYNC pattern, sent LSB first as KJKJKJKK
	localparam logic [7:0] SYNC_BYTE = 8'h80;

	// Reflected form of x^16 + x^15 + x^2 + 1
	localparam logic [15:0] CRC16_POLY_REFL = 16'hA001;

	// Register seed at the start of every data payload
	localparam logic [15:0] CRC16_INIT = 16'hFFFF;

	// Ones in a row before a zero is stuffed
	localparam int STUFF_RUN = 6;

	// Bit times of SE0 at the end of a packet
	localparam int EOP_SE0_BITS = 2;

endpackage

// File: usb_tx.f
src/usb_tx_pkg.sv
src/tx_packet_fifo.sv
src/tx_crc16.sv
src/tx_controller.sv
src/tx_line_encoder.sv
src/usb_tx.sv
bench/tb_usb_tx.sv
